// ==== test/pipe_stimulus.txt ====
# T name | I op rd rs1 rs2 imm | G idle_cycles | E ends the test
# R reg hex | M word hex | S stall_total stall_ex stall_load
T independent_alu
I ADDI 1 0 0 100
I ADDI 2 0 0 37
I ADDI 3 0 0 -5
I ADD 4 1 2 0
I SUB 5 1 3 0
I AND 6 1 2 0
I OR 7 2 3 0
I XOR 8 1 3 0
R 1 00000064
R 2 00000025
R 3 fffffffb
R 4 00000089
R 5 00000069
R 6 00000024
R 7 ffffffff
R 8 ffffff9f
S 0 0 0
E
T back_to_back
I ADDI 1 0 0 10
I ADDI 2 1 0 5
I ADD 3 2 1 0
I SUB 4 3 2 0
I XOR 5 4 3 0
R 2 0000000f
R 3 00000019
R 4 0000000a
R 5 00000013
S 4 4 0
E
T mem_forward
I ADDI 1 0 0 7
I ADDI 9 0 0 1
I ADDI 2 1 0 8
I ADDI 10 0 0 2
I SUB 3 2 9 0
R 2 0000000f
R 3 0000000e
R 9 00000001
S 0 0 0
E
T load_use
I ADDI 1 0 0 85
I ADDI 2 0 0 4
G 2
I ST 0 2 1 3
I LD 3 2 0 3
I ADD 4 3 1 0
I LD 5 2 0 3
I ADDI 6 0 0 1
I ADD 7 5 1 0
R 3 00000055
R 4 000000aa
R 5 00000055
R 6 00000001
R 7 000000aa
M 7 00000055
M 8 00000000
S 3 1 2
E
T reg_zero
I ADDI 0 0 0 99
I ADD 1 0 0 0
I ADDI 0 0 0 7
I ADDI 2 0 0 12
I ADDI 0 0 0 3
I ADD 3 2 0 0
R 0 00000000
R 1 00000000
R 2 0000000c
R 3 0000000c
S 0 0 0
E

// ==== tb.f ====
src/isa_pkg.sv
src/hazard_pkg.sv
src/reg_file.sv
src/hazard_unit.sv
src/exec_alu.sv
src/data_mem.sv
src/pipe_top.sv
test/tb_clock.sv
test/hazard_assert.sv
test/tb_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_top
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = === FAIL ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import isa_pkg::*, hazard_pkg::*;
;

    localparam int    DATA_W         = 32;
    localparam int    MEM_DEPTH      = 64;
    localparam int    MEM_AW         = $clog2(MEM_DEPTH);
    localparam int    ACCEPT_TIMEOUT = 20;
    localparam int    DRAIN_CYCLES   = 4;
    localparam string STIM_FILE      = "test/pipe_stimulus.txt";

    logic                  clk;
    logic                  rst_n;
    logic                  issue;
    op_e                   op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [IMM_W-1:0]      imm;
    logic [REG_ADDR_W-1:0] dbg_reg_addr;
    logic [MEM_AW-1:0]     dbg_mem_addr;
    logic                  stall;
    stall_e                stall_cause;
    logic [DATA_W-1:0]     dbg_reg_data;
    logic [DATA_W-1:0]     dbg_mem_data;

    string             test_name;
    int                errors;
    int                checks;
    int                total_errors;
    int                tests_run;
    int                tests_failed;
    int                stall_total;
    int                stall_ex;
    int                stall_load;
    int                exp_stall [3];
    logic              have_stall_exp;
    logic              aborted;
    int                exp_reg_idx [$];
    logic [DATA_W-1:0] exp_reg_val [$];
    int                exp_mem_idx [$];
    logic [DATA_W-1:0] exp_mem_val [$];

    tb_clock #(.PERIOD_NS(4)) u_clock (.clk(clk));

    pipe_top #(
        .DATA_W    (DATA_W),
        .MEM_DEPTH (MEM_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue        (issue),
        .op           (op),
        .rd           (rd),
        .rs1          (rs1),
        .rs2          (rs2),
        .imm          (imm),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_mem_addr (dbg_mem_addr),
        .stall        (stall),
        .stall_cause  (stall_cause),
        .dbg_reg_data (dbg_reg_data),
        .dbg_mem_data (dbg_mem_data)
    );

    function automatic logic decode_op(input string name, output op_e o);
        logic ok;
        ok = 1'b1;
        case (name)
            "NOP":   o = OP_NOP;
            "ADD":   o = OP_ADD;
            "SUB":   o = OP_SUB;
            "AND":   o = OP_AND;
            "OR":    o = OP_OR;
            "XOR":   o = OP_XOR;
            "ADDI":  o = OP_ADDI;
            "LD":    o = OP_LD;
            "ST":    o = OP_ST;
            default: begin
                o  = OP_NOP;
                ok = 1'b0;
            end
        endcase
        return ok;
    endfunction

    task automatic apply_reset();
        issue = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic idle(input int cycles);
        issue = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // called on a falling edge; returns on the falling edge after acceptance.
    task automatic send_instr(input op_e o, input int d, input int s1, input int s2,
                              input int im);
        int   waits;
        logic accepted;
        waits    = 0;
        accepted = 1'b0;
        op       = o;
        rd       = REG_ADDR_W'(d);
        rs1      = REG_ADDR_W'(s1);
        rs2      = REG_ADDR_W'(s2);
        imm      = IMM_W'(im);
        issue    = 1'b1;
        while (!accepted && !aborted) begin
            #1;
            if (!stall) begin
                accepted = 1'b1;
            end else begin
                stall_total++;
                if (stall_cause == STALL_EX) begin
                    stall_ex++;
                end else if (stall_cause == STALL_LOAD) begin
                    stall_load++;
                end
                waits++;
                if (waits >= ACCEPT_TIMEOUT) begin
                    $display("timeout: the pipeline never accepted the instruction in test %s",
                             test_name);
                    aborted = 1'b1;
                end
            end
            @(negedge clk);
        end
    endtask

    task automatic check_reg(input int idx, input logic [DATA_W-1:0] exp);
        @(negedge clk);
        dbg_reg_addr = REG_ADDR_W'(idx);
        #1;
        checks++;
        assert (dbg_reg_data === exp) else begin
            $display("Error at %0t ns: register x%0d holds %h, expected %h",
                     $time, idx, dbg_reg_data, exp);
            errors++;
        end
    endtask

    task automatic check_mem(input int idx, input logic [DATA_W-1:0] exp);
        @(negedge clk);
        dbg_mem_addr = MEM_AW'(idx);
        #1;
        checks++;
        assert (dbg_mem_data === exp) else begin
            $display("Error at %0t ns: memory word %0d holds %h, expected %h",
                     $time, idx, dbg_mem_data, exp);
            errors++;
        end
    endtask

    task automatic check_stalls();
        checks++;
        assert (stall_total == exp_stall[0] && stall_ex == exp_stall[1]
                && stall_load == exp_stall[2]) else begin
            $display("Error at %0t ns: stall cycles total/ex/load %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, stall_total, stall_ex, stall_load,
                     exp_stall[0], exp_stall[1], exp_stall[2]);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        errors         = 0;
        checks         = 0;
        stall_total    = 0;
        stall_ex       = 0;
        stall_load     = 0;
        have_stall_exp = 1'b0;
        exp_reg_idx.delete();
        exp_reg_val.delete();
        exp_mem_idx.delete();
        exp_mem_val.delete();
        apply_reset();
    endtask

    task automatic finish_test();
        idle(DRAIN_CYCLES);
        while (exp_reg_idx.size() > 0) begin
            check_reg(exp_reg_idx.pop_front(), exp_reg_val.pop_front());
        end
        while (exp_mem_idx.size() > 0) begin
            check_mem(exp_mem_idx.pop_front(), exp_mem_val.pop_front());
        end
        if (have_stall_exp) begin
            check_stalls();
        end
        tests_run++;
        total_errors += errors;
        if (errors > 0) begin
            tests_failed++;
            $display("test %s: failed, %0d of %0d checks wrong", test_name, errors, checks);
        end else begin
            $display("test %s: ok, %0d checks", test_name, checks);
        end
    endtask

    initial begin
        int                  fd;
        int                  a;
        int                  b;
        int                  c;
        int                  e;
        string               kw;
        string               word;
        op_e                 o;
        logic [DATA_W-1:0]   val;
        logic [8*128-1:0]    line_buf;

        rst_n        = 1'b0;
        issue        = 1'b0;
        op           = OP_NOP;
        rd           = '0;
        rs1          = '0;
        rs2          = '0;
        imm          = '0;
        dbg_reg_addr = '0;
        dbg_mem_addr = '0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        test_name    = "none";

        apply_reset();
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            aborted = 1'b1;
        end else begin
            while (!aborted && $fscanf(fd, "%s", kw) == 1) begin
                if (kw.getc(0) == "#") begin
                    void'($fgets(line_buf, fd));
                end else if (kw == "T") begin
                    void'($fscanf(fd, "%s", word));
                    start_test(word);
                end else if (kw == "I") begin
                    void'($fscanf(fd, "%s %d %d %d %d", word, a, b, c, e));
                    if (decode_op(word, o)) begin
                        send_instr(o, a, b, c, e);
                    end else begin
                        $display("unknown opcode %s in the stimulus file", word);
                        errors++;
                    end
                end else if (kw == "G") begin
                    void'($fscanf(fd, "%d", a));
                    idle(a);
                end else if (kw == "R") begin
                    void'($fscanf(fd, "%d %h", a, val));
                    exp_reg_idx.push_back(a);
                    exp_reg_val.push_back(val);
                end else if (kw == "M") begin
                    void'($fscanf(fd, "%d %h", a, val));
                    exp_mem_idx.push_back(a);
                    exp_mem_val.push_back(val);
                end else if (kw == "S") begin
                    void'($fscanf(fd, "%d %d %d", exp_stall[0], exp_stall[1], exp_stall[2]));
                    have_stall_exp = 1'b1;
                end else if (kw == "E") begin
                    finish_test();
                end else begin
                    $display("unknown line kind %s in the stimulus file", kw);
                    total_errors++;
                end
            end
            $fclose(fd);
        end

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (!aborted && tests_run > 0 && tests_failed == 0 && total_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/hazard_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_assert
    import hazard_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   id_valid,
    input logic   stall,
    input stall_e stall_cause,
    input fwd_e   fwd1,
    input fwd_e   fwd2
);

    // a stall only holds back a real instruction.
    assert property (@(posedge clk) disable iff (!rst_n) stall |-> id_valid)
        else $error("stall raised with no instruction at issue");

    assert property (@(posedge clk) disable iff (!rst_n)
        (stall_cause == STALL_NONE) == !stall)
        else $error("stall cause does not agree with the stall level");

    // nothing is bypassed into a bubble.
    assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> (fwd1 == FWD_REG && fwd2 == FWD_REG))
        else $error("operand forwarded from mem while issue is stalled");

endmodule

// the hazard unit has no clock, so its port nets are watched from the top.
bind pipe_top hazard_assert u_hazard_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (issue),
    .stall       (stall),
    .stall_cause (stall_cause),
    .fwd1        (fwd1),
    .fwd2        (fwd2)
);

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== src/pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_top
    import isa_pkg::*, hazard_pkg::*;
#(
    parameter int DATA_W    = 32,
    parameter int MEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         issue,
    input  op_e                          op,
    input  logic [REG_ADDR_W-1:0]        rd,
    input  logic [REG_ADDR_W-1:0]        rs1,
    input  logic [REG_ADDR_W-1:0]        rs2,
    input  logic [IMM_W-1:0]             imm,
    input  logic [REG_ADDR_W-1:0]        dbg_reg_addr,
    input  logic [$clog2(MEM_DEPTH)-1:0] dbg_mem_addr,
    output logic                         stall,
    output stall_e                       stall_cause,
    output logic [DATA_W-1:0]            dbg_reg_data,
    output logic [DATA_W-1:0]            dbg_mem_data
);

    logic [DATA_W-1:0]     rf_rdata1;
    logic [DATA_W-1:0]     rf_rdata2;
    fwd_e                  fwd1;
    fwd_e                  fwd2;
    logic [DATA_W-1:0]     id_a;
    logic [DATA_W-1:0]     id_b;
    logic                  accept;

    logic                  ex_valid;
    op_e                   ex_op;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [DATA_W-1:0]     ex_a;
    logic [DATA_W-1:0]     ex_b;
    logic [IMM_W-1:0]      ex_imm;
    logic [DATA_W-1:0]     ex_result;

    logic                  mem_valid;
    op_e                   mem_op;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [DATA_W-1:0]     mem_result;
    logic [DATA_W-1:0]     mem_sdata;
    logic [DATA_W-1:0]     mem_rdata;

    logic                  wb_valid;
    op_e                   wb_op;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_result;
    logic                  wb_we;
    logic [DATA_W-1:0]     wb_wdata;

    hazard_unit u_hazard (
        .id_valid    (issue),
        .id_op       (op),
        .id_rs1      (rs1),
        .id_rs2      (rs2),
        .ex_valid    (ex_valid),
        .ex_rd       (ex_rd),
        .ex_op       (ex_op),
        .mem_valid   (mem_valid),
        .mem_rd      (mem_rd),
        .mem_op      (mem_op),
        .stall       (stall),
        .stall_cause (stall_cause),
        .fwd1        (fwd1),
        .fwd2        (fwd2)
    );

    reg_file #(.DATA_W(DATA_W)) u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .raddr1   (rs1),
        .raddr2   (rs2),
        .dbg_addr (dbg_reg_addr),
        .we       (wb_we),
        .waddr    (wb_rd),
        .wdata    (wb_wdata),
        .rdata1   (rf_rdata1),
        .rdata2   (rf_rdata2),
        .dbg_data (dbg_reg_data)
    );

    // operand select at issue.
    assign id_a = (fwd1 == FWD_MEM) ? mem_result : rf_rdata1;
    assign id_b = (fwd2 == FWD_MEM) ? mem_result : rf_rdata2;

    assign accept = issue && !stall;

    // a stalled cycle leaves a bubble in ex.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= accept;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op      <= op;
        ex_rd      <= rd;
        ex_a       <= id_a;
        ex_b       <= id_b;
        ex_imm     <= imm;
        mem_op     <= ex_op;
        mem_rd     <= ex_rd;
        mem_result <= ex_result;
        mem_sdata  <= ex_b;
        wb_op      <= mem_op;
        wb_rd      <= mem_rd;
        wb_result  <= mem_result;
    end

    exec_alu #(.DATA_W(DATA_W)) u_alu (
        .op     (ex_op),
        .a      (ex_a),
        .b      (ex_b),
        .imm    (ex_imm),
        .result (ex_result)
    );

    data_mem #(
        .DATA_W    (DATA_W),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_data_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (mem_valid && mem_op == OP_ST),
        .addr     (mem_result),
        .wdata    (mem_sdata),
        .dbg_addr (dbg_mem_addr),
        .rdata    (mem_rdata),
        .dbg_data (dbg_mem_data)
    );

    assign wb_we    = wb_valid && op_writes_rd(wb_op);
    assign wb_wdata = (wb_op == OP_LD) ? mem_rdata : wb_result;

endmodule

`default_nettype wire

// ==== src/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int DATA_W    = 32,
    parameter int MEM_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         we,
    input  logic [DATA_W-1:0]            addr,
    input  logic [DATA_W-1:0]            wdata,
    input  logic [$clog2(MEM_DEPTH)-1:0] dbg_addr,
    output logic [DATA_W-1:0]            rdata,
    output logic [DATA_W-1:0]            dbg_data
);

    localparam int AW = $clog2(MEM_DEPTH);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [AW-1:0]     idx;

    // word index, wrapped into the array.
    assign idx = AW'(addr % MEM_DEPTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wdata;
        end
    end

    // read issued in mem, data lands in wb.
    always_ff @(posedge clk) begin
        rdata <= mem[idx];
    end

    assign dbg_data = mem[dbg_addr];

endmodule

`default_nettype wire

// ==== src/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_alu
    import isa_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  op_e               op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic [IMM_W-1:0]  imm,
    output logic [DATA_W-1:0] result
);

    logic [DATA_W-1:0] imm_ext;

    assign imm_ext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};

    always_comb begin
        unique case (op)
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            // address add shares the immediate path.
            OP_ADDI,
            OP_LD,
            OP_ST:   result = a + imm_ext;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import isa_pkg::*, hazard_pkg::*;
(
    input  logic                  id_valid,
    input  op_e                   id_op,
    input  logic [REG_ADDR_W-1:0] id_rs1,
    input  logic [REG_ADDR_W-1:0] id_rs2,
    input  logic                  ex_valid,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  op_e                   ex_op,
    input  logic                  mem_valid,
    input  logic [REG_ADDR_W-1:0] mem_rd,
    input  op_e                   mem_op,
    output logic                  stall,
    output stall_e                stall_cause,
    output fwd_e                  fwd1,
    output fwd_e                  fwd2
);

    logic use1;
    logic use2;
    logic ex_dst;
    logic mem_dst;
    logic ex_hit;
    logic mem_hit1;
    logic mem_hit2;
    logic load_hit;

    // register 0 never creates a dependency.
    assign use1 = id_valid && (id_op != OP_NOP) && (id_rs1 != '0);
    assign use2 = id_valid && op_uses_rs2(id_op) && (id_rs2 != '0);

    assign ex_dst  = ex_valid && op_writes_rd(ex_op) && (ex_rd != '0);
    assign mem_dst = mem_valid && op_writes_rd(mem_op) && (mem_rd != '0);

    assign ex_hit = ex_dst && ((use1 && id_rs1 == ex_rd) || (use2 && id_rs2 == ex_rd));

    assign mem_hit1 = mem_dst && use1 && (id_rs1 == mem_rd);
    assign mem_hit2 = mem_dst && use2 && (id_rs2 == mem_rd);

    // load data only exists after the memory read, so no bypass from mem.
    assign load_hit = (mem_hit1 || mem_hit2) && (mem_op == OP_LD);

    assign stall = ex_hit || load_hit;

    always_comb begin
        if (ex_hit) begin
            stall_cause = STALL_EX;
        end else if (load_hit) begin
            stall_cause = STALL_LOAD;
        end else begin
            stall_cause = STALL_NONE;
        end
    end

    assign fwd1 = (!stall && mem_hit1) ? FWD_MEM : FWD_REG;
    assign fwd2 = (!stall && mem_hit2) ? FWD_MEM : FWD_REG;

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import isa_pkg::*;
#(
    parameter int DATA_W = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    input  logic [REG_ADDR_W-1:0] dbg_addr,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [DATA_W-1:0]     wdata,
    output logic [DATA_W-1:0]     rdata1,
    output logic [DATA_W-1:0]     rdata2,
    output logic [DATA_W-1:0]     dbg_data
);

    logic [DATA_W-1:0] regs [2**REG_ADDR_W];

    // entry 0 is cleared by reset and never written.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through covers a producer sitting in wb.
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && raddr2 == waddr) ? wdata : regs[raddr2];

    assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// ==== src/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

    typedef enum logic [1:0] {
        STALL_NONE = 2'd0,
        STALL_EX   = 2'd1,
        STALL_LOAD = 2'd2
    } stall_e;

    // operand source at issue.
    typedef enum logic {
        FWD_REG = 1'b0,
        FWD_MEM = 1'b1
    } fwd_e;

endpackage

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 12;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LD   = 4'd7,
        OP_ST   = 4'd8
    } op_e;

    // ops that produce a register result.
    function automatic logic op_writes_rd(input op_e op);
        return (op != OP_NOP) && (op != OP_ST);
    endfunction

    // rs2 is read by reg-reg alu ops and by stores.
    function automatic logic op_uses_rs2(input op_e op);
        return (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ST});
    endfunction

endpackage

`default_nettype wire
